//--- flist.f
+incdir+rtl
rtl/cpr_pkg.sv
rtl/cpr_stream_if.sv
rtl/cpr_regs.sv
rtl/cpr_len_list.sv
rtl/cpr_remover.sv
rtl/cpr_mag_sq.sv
rtl/cpr_top.sv
verif/cpr_checker.sv
verif/cpr_tb.sv

//--- rtl/cpr_consts.svh
/*
 * CP removal front end constants
 * Widths, register map, soft reset length and special read values
 */
`ifndef CPR_CONSTS_SVH
`define CPR_CONSTS_SVH

// Datapath and configuration widths
`define CPR_DATA_W          32
`define CPR_MAX_FFT_LOG2    10
`define CPR_MIN_FFT_LOG2    3
`define CPR_LIST_LOG2       3
`define CPR_FFT_LOG2_W      4
`define CPR_REG_DATA_W      32
`define CPR_REG_ADDR_W      20

`define CPR_RESET_PULSE_LEN 8
`define CPR_COMPAT          32'h0001_0000
`define CPR_BAD_ADDR_DATA   32'h0BAD_C0DE

// Register byte addresses
`define CPR_ADDR_COMPAT       20'h00
`define CPR_ADDR_RESET        20'h04
`define CPR_ADDR_LENGTH_LOG2  20'h08
`define CPR_ADDR_CP_REM_LEN   20'h0C
`define CPR_ADDR_CP_LIST_LOAD 20'h10
`define CPR_ADDR_CP_LIST_CLR  20'h14
`define CPR_ADDR_CP_LIST_OCC  20'h18
`define CPR_ADDR_MAGNITUDE    20'h1C

`endif

//--- rtl/cpr_len_list.sv
/*
 * Circular list of CP removal lengths
 * Loaded from the registers, popped once per symbol by the remover
 */
`default_nettype none

`include "cpr_consts.svh"

module cpr_len_list (
  input  wire                   ce_clk,
  input  wire                   rst_i,
  input  wire                   load_i,
  input  wire                   clr_i,
  input  wire cpr_pkg::cp_len_t cp_len_i,
  input  wire                   pop_i,
  output cpr_pkg::cp_len_t      cp_len_o,
  output cpr_pkg::list_occ_t    occ_o
);

  localparam int unsigned DEPTH = 1 << `CPR_LIST_LOG2;

  cpr_pkg::cp_len_t mem [DEPTH];

  logic [`CPR_LIST_LOG2-1:0] wr_ptr;
  logic [`CPR_LIST_LOG2-1:0] rd_ptr;
  logic                      full;

  assign full = (occ_o == cpr_pkg::list_occ_t'(DEPTH));

  always_ff @(posedge ce_clk) begin
    if (load_i && !full && !clr_i) begin
      mem[wr_ptr] <= cp_len_i;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (rst_i || clr_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ_o  <= '0;
    end else begin
      // Loads beyond the list depth are dropped
      if (load_i && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
        occ_o  <= occ_o + 1'b1;
      end
      // Wrap back to the oldest entry after the last loaded one
      if (pop_i && occ_o != '0) begin
        if ({1'b0, rd_ptr} == occ_o - 1'b1) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Empty list means no prefix
  assign cp_len_o = (occ_o == '0) ? '0 : mem[rd_ptr];

  a_occ_bound: assert property (@(posedge ce_clk) disable iff (rst_i)
    occ_o <= cpr_pkg::list_occ_t'(DEPTH) && (occ_o == '0 || {1'b0, rd_ptr} < occ_o));

endmodule : cpr_len_list

`default_nettype wire

//--- rtl/cpr_mag_sq.sv
/*
 * Output stage with optional magnitude squared
 * One register slice with a skid buffer for full throughput
 */
`default_nettype none

module cpr_mag_sq (
  input  wire         ce_clk,
  input  wire         rst_i,
  input  wire         mag_en_i,
  cpr_stream_if.snk   s,
  output cpr_pkg::sample_t out_tdata_o,
  output logic        out_tlast_o,
  output logic        out_tvalid_o,
  input  wire         out_tready_i
);

  logic signed [15:0] i_s;
  logic signed [15:0] q_s;
  cpr_pkg::sample_t   i_sq;
  cpr_pkg::sample_t   q_sq;
  cpr_pkg::sample_t   proc_data;
  cpr_pkg::sample_t   skid_data;
  logic               skid_last;
  logic               skid_valid;
  logic               in_fire;

  // I in the upper half, Q in the lower half
  assign i_s = s.tdata[31:16];
  assign q_s = s.tdata[15:0];

  // Each square is at most 2^30, so the sum fits unsigned in 32 bits
  assign i_sq      = i_s * i_s;
  assign q_sq      = q_s * q_s;
  assign proc_data = mag_en_i ? (i_sq + q_sq) : s.tdata;

  assign s.tready = !skid_valid;
  assign in_fire  = s.tvalid && !skid_valid;

  always_ff @(posedge ce_clk) begin
    if (rst_i) begin
      out_tvalid_o <= 1'b0;
      skid_valid   <= 1'b0;
    end else if (!out_tvalid_o || out_tready_i) begin
      // Output free, refill from skid first
      out_tvalid_o <= skid_valid || in_fire;
      skid_valid   <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!out_tvalid_o || out_tready_i) begin
      if (skid_valid) begin
        out_tdata_o <= skid_data;
        out_tlast_o <= skid_last;
      end else if (in_fire) begin
        out_tdata_o <= proc_data;
        out_tlast_o <= s.tlast;
      end
    end else if (in_fire) begin
      skid_data <= proc_data;
      skid_last <= s.tlast;
    end
  end

endmodule : cpr_mag_sq

`default_nettype wire

//--- rtl/cpr_pkg.sv
/*
 * CP removal front end types
 * Vector types for meaningful widths and the state machine encodings
 */
`default_nettype none

`include "cpr_consts.svh"

package cpr_pkg;

  // One complex sample, I in the upper half and Q in the lower half
  typedef logic [`CPR_DATA_W-1:0] sample_t;

  // CP length is at most the largest symbol size minus 1
  typedef logic [`CPR_MAX_FFT_LOG2-1:0] cp_len_t;
  typedef logic [`CPR_FFT_LOG2_W-1:0]   fft_log2_t;
  typedef logic [`CPR_MAX_FFT_LOG2:0]   sym_cnt_t;
  typedef logic [`CPR_LIST_LOG2:0]      list_occ_t;

  typedef logic [`CPR_REG_DATA_W-1:0] reg_data_t;
  typedef logic [`CPR_REG_ADDR_W-1:0] reg_addr_t;

  // Soft reset sequencer
  typedef enum logic [0:0] {RST_IDLE, RST_ASSERT} rst_state_t;

  // CP remover, dropping prefix or passing the symbol body
  typedef enum logic [0:0] {REM_DROP, REM_PASS} rem_state_t;

endpackage : cpr_pkg

`default_nettype wire

//--- rtl/cpr_regs.sv
/*
 * Control registers for the CP removal front end
 * Register port decode, list strobes and the soft reset sequencer
 */
`default_nettype none

`include "cpr_consts.svh"

module cpr_regs (
  input  wire                  ce_clk,
  input  wire                  ce_rst,
  input  wire                  req_wr_i,
  input  wire                  req_rd_i,
  input  wire cpr_pkg::reg_addr_t req_addr_i,
  input  wire cpr_pkg::reg_data_t req_data_i,
  input  wire cpr_pkg::list_occ_t list_occ_i,
  output logic                 resp_ack_o,
  output cpr_pkg::reg_data_t   resp_data_o,
  output logic                 core_rst_o,
  output cpr_pkg::fft_log2_t   fft_log2_o,
  output cpr_pkg::cp_len_t     cp_len_o,
  output logic                 load_o,
  output logic                 clr_o,
  output logic                 mag_en_o
);

  cpr_pkg::reg_addr_t  addr_aligned;
  logic                user_rst;
  cpr_pkg::rst_state_t rst_state;
  logic [$clog2(`CPR_RESET_PULSE_LEN)-1:0] rst_cnt;

  // Byte address down to a word address
  assign addr_aligned = {req_addr_i[`CPR_REG_ADDR_W-1:2], 2'b00};

  //--------------------------------------------------------------------------
  // Register port
  //--------------------------------------------------------------------------

  // The port keeps answering during a soft reset
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      resp_ack_o <= 1'b0;
    end else begin
      resp_ack_o <= req_wr_i | req_rd_i;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (req_rd_i) begin
      case (addr_aligned)
        `CPR_ADDR_COMPAT:      resp_data_o <= `CPR_COMPAT;
        `CPR_ADDR_LENGTH_LOG2: resp_data_o <= cpr_pkg::reg_data_t'(fft_log2_o);
        `CPR_ADDR_CP_REM_LEN:  resp_data_o <= cpr_pkg::reg_data_t'(cp_len_o);
        `CPR_ADDR_CP_LIST_OCC: resp_data_o <= cpr_pkg::reg_data_t'(list_occ_i);
        `CPR_ADDR_MAGNITUDE:   resp_data_o <= cpr_pkg::reg_data_t'(mag_en_o);
        default:               resp_data_o <= `CPR_BAD_ADDR_DATA;
      endcase
    end
  end

  always_ff @(posedge ce_clk) begin
    if (core_rst_o) begin
      fft_log2_o <= cpr_pkg::fft_log2_t'(`CPR_MAX_FFT_LOG2);
      cp_len_o   <= '0;
      mag_en_o   <= 1'b0;
      load_o     <= 1'b0;
      clr_o      <= 1'b0;
      user_rst   <= 1'b0;
    end else begin
      // Strobes last a single cycle
      load_o   <= 1'b0;
      clr_o    <= 1'b0;
      user_rst <= 1'b0;
      if (req_wr_i) begin
        case (addr_aligned)
          `CPR_ADDR_RESET:         user_rst <= 1'b1;
          `CPR_ADDR_CP_REM_LEN:    cp_len_o <= cpr_pkg::cp_len_t'(req_data_i);
          `CPR_ADDR_CP_LIST_LOAD:  load_o   <= 1'b1;
          `CPR_ADDR_CP_LIST_CLR:   clr_o    <= 1'b1;
          `CPR_ADDR_MAGNITUDE:     mag_en_o <= req_data_i[0];
          `CPR_ADDR_LENGTH_LOG2: begin
            // Clamp into the supported symbol sizes
            if (req_data_i < `CPR_MIN_FFT_LOG2) begin
              fft_log2_o <= cpr_pkg::fft_log2_t'(`CPR_MIN_FFT_LOG2);
            end else if (req_data_i > `CPR_MAX_FFT_LOG2) begin
              fft_log2_o <= cpr_pkg::fft_log2_t'(`CPR_MAX_FFT_LOG2);
            end else begin
              fft_log2_o <= cpr_pkg::fft_log2_t'(req_data_i);
            end
          end
          default: ;
        endcase
      end
    end
  end

  //--------------------------------------------------------------------------
  // Soft reset sequencer
  //--------------------------------------------------------------------------

  // Stretches the RESET strobe, and ce_rst, into a core reset pulse
  always_ff @(posedge ce_clk) begin
    if (ce_rst) begin
      rst_state  <= cpr_pkg::RST_ASSERT;
      rst_cnt    <= '0;
      core_rst_o <= 1'b1;
    end else begin
      case (rst_state)
        cpr_pkg::RST_IDLE: begin
          rst_cnt <= '0;
          if (user_rst) begin
            core_rst_o <= 1'b1;
            rst_state  <= cpr_pkg::RST_ASSERT;
          end
        end
        cpr_pkg::RST_ASSERT: begin
          rst_cnt <= rst_cnt + 1'b1;
          if (rst_cnt == `CPR_RESET_PULSE_LEN - 1) begin
            rst_cnt    <= '0;
            core_rst_o <= 1'b0;
            rst_state  <= cpr_pkg::RST_IDLE;
          end
        end
        default: rst_state <= cpr_pkg::RST_IDLE;
      endcase
    end
  end

  // Every acknowledge answers a request in the previous cycle
  a_ack_after_req: assert property (@(posedge ce_clk) disable iff (ce_rst)
    resp_ack_o |-> $past(req_wr_i || req_rd_i));

endmodule : cpr_regs

`default_nettype wire

//--- rtl/cpr_remover.sv
/*
 * Cyclic prefix remover
 * Drops the CP samples of each symbol and marks the symbol end with tlast
 */
`default_nettype none

module cpr_remover (
  input  wire                     ce_clk,
  input  wire                     rst_i,
  input  wire cpr_pkg::sample_t   in_tdata_i,
  input  wire                     in_tvalid_i,
  output logic                    in_tready_o,
  input  wire cpr_pkg::fft_log2_t fft_log2_i,
  input  wire cpr_pkg::cp_len_t   cp_len_i,
  output logic                    pop_o,
  cpr_stream_if.src               m
);

  cpr_pkg::rem_state_t state;
  cpr_pkg::sym_cnt_t   cnt;
  cpr_pkg::sym_cnt_t   last_idx;
  cpr_pkg::sym_cnt_t   pass_idx;
  cpr_pkg::cp_len_t    cp_lat;
  cpr_pkg::cp_len_t    cur_len;
  logic                in_fire;
  logic                sym_start;
  logic                keep;
  logic                pass_last;
  logic                out_valid;
  logic                out_last;
  cpr_pkg::sample_t    out_data;

  assign in_tready_o = !out_valid || m.tready;
  assign in_fire     = in_tvalid_i && in_tready_o;

  // First sample of a symbol takes the list head directly
  assign sym_start = (state == cpr_pkg::REM_DROP) && (cnt == '0);
  assign cur_len   = sym_start ? cp_len_i : cp_lat;
  assign pop_o     = in_fire && sym_start;

  assign last_idx  = (cpr_pkg::sym_cnt_t'(1) << fft_log2_i) - 1'b1;
  assign pass_idx  = (state == cpr_pkg::REM_PASS) ? cnt : '0;
  assign pass_last = (pass_idx == last_idx);
  assign keep      = (state == cpr_pkg::REM_PASS) || (cur_len == '0);

  always_ff @(posedge ce_clk) begin
    if (rst_i) begin
      state  <= cpr_pkg::REM_DROP;
      cnt    <= '0;
      cp_lat <= '0;
    end else if (in_fire) begin
      case (state)
        cpr_pkg::REM_DROP: begin
          if (sym_start) begin
            cp_lat <= cp_len_i;
          end
          if (cur_len == '0) begin
            // No prefix, this sample is the symbol's first
            state <= cpr_pkg::REM_PASS;
            cnt   <= cpr_pkg::sym_cnt_t'(1);
          end else if (cnt + 1'b1 == cpr_pkg::sym_cnt_t'(cur_len)) begin
            state <= cpr_pkg::REM_PASS;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        cpr_pkg::REM_PASS: begin
          if (pass_last) begin
            state <= cpr_pkg::REM_DROP;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= cpr_pkg::REM_DROP;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Output register
  //--------------------------------------------------------------------------

  always_ff @(posedge ce_clk) begin
    if (rst_i) begin
      out_valid <= 1'b0;
    end else if (in_fire && keep) begin
      out_valid <= 1'b1;
    end else if (m.tready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (in_fire && keep) begin
      out_data <= in_tdata_i;
      out_last <= pass_last;
    end
  end

  assign m.tvalid = out_valid;
  assign m.tdata  = out_data;
  assign m.tlast  = out_last;

  a_stall_stable: assert property (@(posedge ce_clk) disable iff (rst_i)
    m.tvalid && !m.tready |=> m.tvalid && $stable(m.tdata) && $stable(m.tlast));

endmodule : cpr_remover

`default_nettype wire

//--- rtl/cpr_stream_if.sv
/*
 * Sample stream with valid/ready handshake and tlast symbol framing
 */
`default_nettype none

interface cpr_stream_if;

  cpr_pkg::sample_t tdata;
  logic             tlast;
  logic             tvalid;
  logic             tready;

  // Source holds tvalid and payload until tready
  modport src (
    output tdata, tlast, tvalid,
    input  tready
  );

  modport snk (
    input  tdata, tlast, tvalid,
    output tready
  );

endinterface : cpr_stream_if

`default_nettype wire

//--- rtl/cpr_top.sv
/*
 * OFDM receive front end with CP removal and magnitude squared output
 */
`default_nettype none

module cpr_top (
  input  wire                     ce_clk,
  input  wire                     ce_rst,
  // Register port
  input  wire                     ctrl_req_wr_i,
  input  wire                     ctrl_req_rd_i,
  input  wire cpr_pkg::reg_addr_t ctrl_req_addr_i,
  input  wire cpr_pkg::reg_data_t ctrl_req_data_i,
  output logic                    ctrl_resp_ack_o,
  output cpr_pkg::reg_data_t      ctrl_resp_data_o,
  // Sample input
  input  wire cpr_pkg::sample_t   in_tdata_i,
  input  wire                     in_tvalid_i,
  output logic                    in_tready_o,
  // Symbol output
  output cpr_pkg::sample_t        out_tdata_o,
  output logic                    out_tlast_o,
  output logic                    out_tvalid_o,
  input  wire                     out_tready_i
);

  logic                core_rst;
  logic                list_load;
  logic                list_clr;
  logic                list_pop;
  logic                mag_en;
  cpr_pkg::fft_log2_t  fft_log2;
  cpr_pkg::cp_len_t    reg_cp_len;
  cpr_pkg::cp_len_t    head_cp_len;
  cpr_pkg::list_occ_t  list_occ;

  cpr_stream_if rem_s ();

  cpr_regs u_regs (
    .ce_clk      (ce_clk),
    .ce_rst      (ce_rst),
    .req_wr_i    (ctrl_req_wr_i),
    .req_rd_i    (ctrl_req_rd_i),
    .req_addr_i  (ctrl_req_addr_i),
    .req_data_i  (ctrl_req_data_i),
    .list_occ_i  (list_occ),
    .resp_ack_o  (ctrl_resp_ack_o),
    .resp_data_o (ctrl_resp_data_o),
    .core_rst_o  (core_rst),
    .fft_log2_o  (fft_log2),
    .cp_len_o    (reg_cp_len),
    .load_o      (list_load),
    .clr_o       (list_clr),
    .mag_en_o    (mag_en)
  );

  cpr_len_list u_len_list (
    .ce_clk   (ce_clk),
    .rst_i    (core_rst),
    .load_i   (list_load),
    .clr_i    (list_clr),
    .cp_len_i (reg_cp_len),
    .pop_i    (list_pop),
    .cp_len_o (head_cp_len),
    .occ_o    (list_occ)
  );

  cpr_remover u_remover (
    .ce_clk      (ce_clk),
    .rst_i       (core_rst),
    .in_tdata_i  (in_tdata_i),
    .in_tvalid_i (in_tvalid_i),
    .in_tready_o (in_tready_o),
    .fft_log2_i  (fft_log2),
    .cp_len_i    (head_cp_len),
    .pop_o       (list_pop),
    .m           (rem_s.src)
  );

  cpr_mag_sq u_mag_sq (
    .ce_clk       (ce_clk),
    .rst_i        (core_rst),
    .mag_en_i     (mag_en),
    .s            (rem_s.snk),
    .out_tdata_o  (out_tdata_o),
    .out_tlast_o  (out_tlast_o),
    .out_tvalid_o (out_tvalid_o),
    .out_tready_i (out_tready_i)
  );

endmodule : cpr_top

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the CP removal testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module cpr_tb -o cpr_sim

./obj_dir/cpr_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

//--- verif/cpr_checker.sv
/*
 * Scoreboard for the CP removal front end
 * Reference model of the list and CP removal, compares reads and output samples
 */
`default_nettype none

`include "cpr_consts.svh"

module cpr_checker (
  input wire        ce_clk,
  input wire        ce_rst,
  input wire        ctrl_req_wr_i,
  input wire        ctrl_req_rd_i,
  input wire [19:0] ctrl_req_addr_i,
  input wire [31:0] ctrl_req_data_i,
  input wire        ctrl_resp_ack_i,
  input wire [31:0] ctrl_resp_data_i,
  input wire [31:0] in_tdata_i,
  input wire        in_tvalid_i,
  input wire        in_tready_i,
  input wire [31:0] out_tdata_i,
  input wire        out_tlast_i,
  input wire        out_tvalid_i,
  input wire        out_tready_i
);

  int          error_count;
  int          check_count;
  int          out_count;
  int          last_count;
  string       test_name;

  // Reference state
  int          log2_m;
  logic [9:0]  cp_reg_m;
  bit          mag_m;
  int          list_m[$];
  int          rd_m;
  bit          in_sym;
  int          drop_left;
  int          pass_left;

  logic [31:0] exp_data_q[$];
  bit          exp_last_q[$];
  logic [31:0] exp_rd_q[$];
  string       exp_rd_name_q[$];
  bit          prev_req;
  bit          prev_rd;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic expect_read(input string name, input logic [31:0] value);
    exp_rd_name_q.push_back(name);
    exp_rd_q.push_back(value);
  endtask

  function automatic int pending();
    return exp_data_q.size();
  endfunction

  // Defaults after any reset
  task automatic reset_model();
    log2_m    = `CPR_MAX_FFT_LOG2;
    cp_reg_m  = '0;
    mag_m     = 1'b0;
    rd_m      = 0;
    in_sym    = 1'b0;
    drop_left = 0;
    pass_left = 0;
    list_m.delete();
  endtask

  function automatic logic [31:0] mag_of(input logic [31:0] d);
    int i_v;
    int q_v;
    i_v = $signed(d[31:16]);
    q_v = $signed(d[15:0]);
    return 32'(i_v * i_v + q_v * q_v);
  endfunction

  task automatic apply_write(input logic [19:0] addr, input logic [31:0] data);
    case ({addr[19:2], 2'b00})
      `CPR_ADDR_RESET:        reset_model();
      `CPR_ADDR_CP_REM_LEN:   cp_reg_m = data[9:0];
      `CPR_ADDR_MAGNITUDE:    mag_m = data[0];
      `CPR_ADDR_CP_LIST_CLR: begin
        list_m.delete();
        rd_m = 0;
      end
      `CPR_ADDR_CP_LIST_LOAD: begin
        if (list_m.size() < (1 << `CPR_LIST_LOG2)) begin
          list_m.push_back(int'(cp_reg_m));
        end
      end
      `CPR_ADDR_LENGTH_LOG2: begin
        if (data < `CPR_MIN_FFT_LOG2) begin
          log2_m = `CPR_MIN_FFT_LOG2;
        end else if (data > `CPR_MAX_FFT_LOG2) begin
          log2_m = `CPR_MAX_FFT_LOG2;
        end else begin
          log2_m = int'(data);
        end
      end
      default: ;
    endcase
  endtask

  // Head of the list is taken and popped on the first sample of a symbol
  task automatic accept_sample(input logic [31:0] d);
    if (!in_sym) begin
      if (list_m.size() == 0) begin
        drop_left = 0;
      end else begin
        drop_left = list_m[rd_m];
        rd_m      = (rd_m + 1) % list_m.size();
      end
      pass_left = 1 << log2_m;
      in_sym    = 1'b1;
    end
    if (drop_left > 0) begin
      drop_left--;
    end else begin
      exp_data_q.push_back(mag_m ? mag_of(d) : d);
      exp_last_q.push_back(pass_left == 1);
      pass_left--;
      if (pass_left == 0) begin
        in_sym = 1'b0;
      end
    end
  endtask

  task automatic compare_output();
    logic [31:0] exp_d;
    bit          exp_l;
    if (exp_data_q.size() == 0) begin
      $display("%s: output sample 0x%08h arrived with nothing expected", test_name,
               out_tdata_i);
      error_count++;
    end else begin
      exp_d = exp_data_q.pop_front();
      exp_l = exp_last_q.pop_front();
      check_count++;
      if (out_tdata_i !== exp_d) begin
        $display("ERROR %s: expected data 0x%08h actual 0x%08h", test_name, exp_d,
                 out_tdata_i);
        error_count++;
      end
      if (out_tlast_i !== exp_l) begin
        $display("ERROR %s: expected tlast %0b actual %0b", test_name, exp_l, out_tlast_i);
        error_count++;
      end
    end
    out_count++;
    if (out_tlast_i === 1'b1) begin
      last_count++;
    end
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
    out_count   = 0;
    last_count  = 0;
    test_name   = "reset";
    prev_req    = 1'b0;
    prev_rd     = 1'b0;
    reset_model();
  end

  // Sampled at the falling edge, where every port is settled
  always @(negedge ce_clk) begin
    if (ce_rst) begin
      reset_model();
      prev_req = 1'b0;
      prev_rd  = 1'b0;
    end else begin
      if (ctrl_resp_ack_i !== prev_req) begin
        $display("ERROR %s: expected ack %0b actual %0b", test_name, prev_req,
                 ctrl_resp_ack_i);
        error_count++;
      end
      // Input back-pressure only appears once the output holds a sample
      if (in_tready_i !== 1'b1 && out_tvalid_i !== 1'b1) begin
        $display("%s: input not ready while the output stage is empty", test_name);
        error_count++;
      end
      if (ctrl_resp_ack_i === 1'b1 && prev_rd) begin
        if (exp_rd_q.size() == 0) begin
          $display("%s: read data returned with no expected value", test_name);
          error_count++;
        end else begin
          check_count++;
          if (ctrl_resp_data_i !== exp_rd_q[0]) begin
            $display("ERROR %s: expected read 0x%08h actual 0x%08h", exp_rd_name_q[0],
                     exp_rd_q[0], ctrl_resp_data_i);
            error_count++;
          end
          void'(exp_rd_q.pop_front());
          void'(exp_rd_name_q.pop_front());
        end
      end
      prev_req = ctrl_req_wr_i || ctrl_req_rd_i;
      prev_rd  = ctrl_req_rd_i;
      if (ctrl_req_wr_i) begin
        apply_write(ctrl_req_addr_i, ctrl_req_data_i);
      end
      if (in_tvalid_i && in_tready_i) begin
        accept_sample(in_tdata_i);
      end
      if (out_tvalid_i && out_tready_i) begin
        compare_output();
      end
    end
  end

endmodule : cpr_checker

`default_nettype wire

//--- verif/cpr_tb.sv
/*
 * Testbench for the CP removal front end
 * Table driven register and sample stimulus under random output back-pressure
 */
`default_nettype none

`include "cpr_consts.svh"

module cpr_tb;

  localparam int OP_WR   = 0;
  localparam int OP_RD   = 1;
  localparam int OP_SEND = 2;

  logic               ce_clk;
  logic               ce_rst;
  logic               ctrl_req_wr_i;
  logic               ctrl_req_rd_i;
  cpr_pkg::reg_addr_t ctrl_req_addr_i;
  cpr_pkg::reg_data_t ctrl_req_data_i;
  logic               ctrl_resp_ack_o;
  cpr_pkg::reg_data_t ctrl_resp_data_o;
  cpr_pkg::sample_t   in_tdata_i;
  logic               in_tvalid_i;
  logic               in_tready_o;
  cpr_pkg::sample_t   out_tdata_o;
  logic               out_tlast_o;
  logic               out_tvalid_o;
  logic               out_tready_i;

  // Stimulus table, one entry per row in each queue
  // For OP_SEND rows, addr holds the symbol count, data the input samples,
  // exp the output samples
  int          row_op[$];
  logic [31:0] row_addr[$];
  logic [31:0] row_data[$];
  logic [31:0] row_exp[$];
  string       row_name[$];

  integer      seed;
  logic [31:0] sample_idx;
  int          cycles;
  int          limit;
  int          tb_errors;

  cpr_top DUT (.*);

  cpr_checker u_checker (
    .ce_clk           (ce_clk),
    .ce_rst           (ce_rst),
    .ctrl_req_wr_i    (ctrl_req_wr_i),
    .ctrl_req_rd_i    (ctrl_req_rd_i),
    .ctrl_req_addr_i  (ctrl_req_addr_i),
    .ctrl_req_data_i  (ctrl_req_data_i),
    .ctrl_resp_ack_i  (ctrl_resp_ack_o),
    .ctrl_resp_data_i (ctrl_resp_data_o),
    .in_tdata_i       (in_tdata_i),
    .in_tvalid_i      (in_tvalid_i),
    .in_tready_i      (in_tready_o),
    .out_tdata_i      (out_tdata_o),
    .out_tlast_i      (out_tlast_o),
    .out_tvalid_i     (out_tvalid_o),
    .out_tready_i     (out_tready_i)
  );

  initial begin
    ce_clk = 1'b0;
    forever #20 ce_clk = ~ce_clk;
  end

  //--------------------------------------------------------------------------
  // Table
  //--------------------------------------------------------------------------

  task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] exp, input string name);
    row_op.push_back(op);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_exp.push_back(exp);
    row_name.push_back(name);
  endtask

  task automatic build_table();
    add_row(OP_RD,   `CPR_ADDR_COMPAT,       0,     `CPR_COMPAT,        "compat");
    add_row(OP_RD,   32'h40,                 0,     `CPR_BAD_ADDR_DATA, "bad_addr");
    add_row(OP_RD,   `CPR_ADDR_LENGTH_LOG2,  0,     `CPR_MAX_FFT_LOG2,  "len_default");
    add_row(OP_WR,   `CPR_ADDR_LENGTH_LOG2,  5,     0,                  "len_rw");
    add_row(OP_RD,   `CPR_ADDR_LENGTH_LOG2,  0,     5,                  "len_rw");
    add_row(OP_WR,   `CPR_ADDR_LENGTH_LOG2,  1,     0,                  "len_clamp");
    add_row(OP_RD,   `CPR_ADDR_LENGTH_LOG2,  0,     `CPR_MIN_FFT_LOG2,  "len_clamp");
    add_row(OP_WR,   `CPR_ADDR_CP_REM_LEN,   'h123, 0,                  "cp_rw");
    add_row(OP_RD,   `CPR_ADDR_CP_REM_LEN,   0,     'h123,              "cp_rw");
    add_row(OP_WR,   `CPR_ADDR_MAGNITUDE,    1,     0,                  "mag_rw");
    add_row(OP_RD,   `CPR_ADDR_MAGNITUDE,    0,     1,                  "mag_rw");
    add_row(OP_WR,   `CPR_ADDR_MAGNITUDE,    0,     0,                  "mag_rw");
    add_row(OP_RD,   `CPR_ADDR_MAGNITUDE,    0,     0,                  "mag_rw");
    // Empty list with 8 sample symbols
    add_row(OP_SEND, 3,                      24,    24,                 "no_cp");
    add_row(OP_WR,   `CPR_ADDR_CP_REM_LEN,   2,     0,                  "cp_list");
    add_row(OP_WR,   `CPR_ADDR_CP_LIST_LOAD, 0,     0,                  "cp_list");
    add_row(OP_WR,   `CPR_ADDR_CP_REM_LEN,   5,     0,                  "cp_list");
    add_row(OP_WR,   `CPR_ADDR_CP_LIST_LOAD, 0,     0,                  "cp_list");
    add_row(OP_RD,   `CPR_ADDR_CP_LIST_OCC,  0,     2,                  "cp_list_occ");
    add_row(OP_SEND, 4,                      46,    32,                 "cp_list");
    add_row(OP_WR,   `CPR_ADDR_CP_LIST_CLR,  0,     0,                  "list_clr");
    add_row(OP_RD,   `CPR_ADDR_CP_LIST_OCC,  0,     0,                  "list_clr");
    add_row(OP_SEND, 2,                      16,    16,                 "list_clr");
    add_row(OP_WR,   `CPR_ADDR_CP_REM_LEN,   3,     0,                  "mag_sq");
    add_row(OP_WR,   `CPR_ADDR_CP_LIST_LOAD, 0,     0,                  "mag_sq");
    add_row(OP_WR,   `CPR_ADDR_MAGNITUDE,    1,     0,                  "mag_sq");
    add_row(OP_SEND, 3,                      33,    24,                 "mag_sq");
    add_row(OP_WR,   `CPR_ADDR_RESET,        1,     0,                  "soft_rst");
    add_row(OP_RD,   `CPR_ADDR_LENGTH_LOG2,  0,     `CPR_MAX_FFT_LOG2,  "soft_rst");
    add_row(OP_RD,   `CPR_ADDR_CP_REM_LEN,   0,     0,                  "soft_rst");
    add_row(OP_RD,   `CPR_ADDR_CP_LIST_OCC,  0,     0,                  "soft_rst");
    add_row(OP_RD,   `CPR_ADDR_MAGNITUDE,    0,     0,                  "soft_rst");
  endtask

  function automatic int total_samples();
    int sum;
    sum = 0;
    foreach (row_op[r]) begin
      if (row_op[r] == OP_SEND) begin
        sum += int'(row_data[r]);
      end
    end
    return sum;
  endfunction

  //--------------------------------------------------------------------------
  // Drivers
  //--------------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge ce_clk);
    #2;
  endtask

  // One request cycle; the acknowledge follows in the next cycle
  task automatic reg_access(input bit wr, input logic [31:0] addr, input logic [31:0] data);
    ctrl_req_wr_i   = wr;
    ctrl_req_rd_i   = !wr;
    ctrl_req_addr_i = addr[19:0];
    ctrl_req_data_i = data;
    next_cycle();
    ctrl_req_wr_i = 1'b0;
    ctrl_req_rd_i = 1'b0;
    next_cycle();
  endtask

  // Samples are consecutive indices, held until accepted
  task automatic send_samples(input int count);
    bit took;
    for (int k = 0; k < count; k++) begin
      in_tvalid_i = 1'b1;
      in_tdata_i  = sample_idx;
      do begin
        @(negedge ce_clk);
        took = in_tready_o;
        next_cycle();
      end while (!took);
      sample_idx = sample_idx + 1;
    end
    in_tvalid_i = 1'b0;
  endtask

  task automatic run_row(input int r);
    int out_start;
    int last_start;
    u_checker.set_test(row_name[r]);
    case (row_op[r])
      OP_WR: begin
        reg_access(1'b1, row_addr[r], row_data[r]);
        // Core reset starts two cycles after the request
        if (row_addr[r] == `CPR_ADDR_RESET) begin
          repeat (`CPR_RESET_PULSE_LEN + 3) next_cycle();
        end
      end
      OP_RD: begin
        u_checker.expect_read(row_name[r], row_exp[r]);
        reg_access(1'b0, row_addr[r], 32'h0);
      end
      default: begin
        out_start  = u_checker.out_count;
        last_start = u_checker.last_count;
        send_samples(int'(row_data[r]));
        while (u_checker.out_count - out_start < int'(row_exp[r])) begin
          next_cycle();
        end
        if (u_checker.last_count - last_start != int'(row_addr[r])) begin
          $display("ERROR %s: expected %0d symbols actual %0d", row_name[r],
                   row_addr[r], u_checker.last_count - last_start);
          tb_errors++;
        end
        if (u_checker.pending() != 0) begin
          $display("%s: reference model still waits for %0d output samples",
                   row_name[r], u_checker.pending());
          tb_errors++;
        end
      end
    endcase
  endtask

  // Random back-pressure, ready about three cycles in four
  always @(posedge ce_clk) begin
    #2;
    out_tready_i = (($random(seed) & 3) != 0);
  end

  always @(posedge ce_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    ce_rst          = 1'b1;
    ctrl_req_wr_i   = 1'b0;
    ctrl_req_rd_i   = 1'b0;
    ctrl_req_addr_i = '0;
    ctrl_req_data_i = '0;
    in_tdata_i      = '0;
    in_tvalid_i     = 1'b0;
    out_tready_i    = 1'b0;
    seed            = 50;
    sample_idx      = 32'hFFFE_FFA0;
    cycles          = 0;
    tb_errors       = 0;
    build_table();
    limit = 4 * total_samples() + 200;

    repeat (8) @(posedge ce_clk);
    #2;
    ce_rst = 1'b0;
    // Core reset outlasts ce_rst by one pulse
    repeat (`CPR_RESET_PULSE_LEN + 2) next_cycle();

    for (int r = 0; r < row_op.size(); r++) begin
      run_row(r);
    end
    repeat (4) next_cycle();

    $display("Checks: %0d, checker errors: %0d, testbench errors: %0d",
             u_checker.check_count, u_checker.error_count, tb_errors);
    if (u_checker.error_count == 0 && tb_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : cpr_tb

`default_nettype wire
